//--- src.f
+incdir+source
+incdir+verification
source/snd_bus_pkg.sv
source/snd_audio_pkg.sv
source/snd_regs.sv
source/adpcm_voice.sv
source/sample_fifo.sv
source/snd_mixer.sv
source/snd_board_top.sv
verification/snd_board_tb.sv

//--- verification/snd_board_ref.svh
`ifndef SND_BOARD_REF_SVH
`define SND_BOARD_REF_SVH

// needs rom_mem and ad_pending in the including module

// one msm6295 nibble, sample and step index updated in place
function automatic void adpcm_nibble(input logic [3:0] nib, inout int smp, inout int idx);
    int step;
    int diff;
    step = snd_audio_pkg::STEP_TABLE[idx];
    diff = step / 8;                   // always present
    if (nib[0]) diff += step / 4;
    if (nib[1]) diff += step / 2;
    if (nib[2]) diff += step;
    smp = nib[3] ? smp - diff : smp + diff; // bit 3 is the sign
    if (smp > 2047) smp = 2047;
    if (smp < -2047) smp = -2047;
    idx += int'(snd_audio_pkg::INDEX_ADJ[nib[2:0]]);
    if (idx < 0) idx = 0;
    if (idx > 48) idx = 48;            // last step table entry
endfunction

// decodes nbytes from first, high nibble first
// results wait in ad_pending for an fm partner
function automatic void decode_range(input int first, input int nbytes);
    int smp;
    int idx;
    logic [7:0] b;
    smp = 0; // decoder restarts on every play
    idx = 0;
    for (int i = 0; i < nbytes; i++) begin
        b = rom_mem[first + i];
        adpcm_nibble(b[7:4], smp, idx);
        ad_pending.push_back(smp);
        adpcm_nibble(b[3:0], smp, idx);
        ad_pending.push_back(smp);
    end
endfunction

// 4x scaled adpcm at 1.5x gain is 6x, then clamp to 16 bits
function automatic int mix_expect(input int fm, input int ad);
    int total;
    total = fm + 6 * ad;
    if (total > 32767) total = 32767;
    if (total < -32768) total = -32768;
    return total;
endfunction

`endif

//--- verification/snd_board_tb.sv
`include "snd_params.svh"

module snd_board_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // fm pushes per behavior: pass-through, playback, saturation, burst, replay
    localparam int TOTAL_PUSHES = 20 + 24 + 16 + 32 + 14;
    localparam int TIMEOUT_CYCLES = TOTAL_PUSHES * `SND_ADPCM_DIV * 4 + 2000;
    localparam int LOUD_BASE = 32'h30000; // rom region with loud nibbles

    logic                       clk = 1'b0;
    logic                       reset;
    logic [2:0]                 addr;
    logic [7:0]                 wdata;
    logic                       wr;
    logic [7:0]                 rdata;
    logic [`SND_ROM_AW-1:0]     rom_addr;
    logic                       rom_cs;
    logic [7:0]                 rom_data;
    logic                       rom_ok;
    logic                       fm_push;
    snd_audio_pkg::fm_sample_t  fm_data;
    logic                       fm_credit;
    snd_audio_pkg::mix_sample_t sound;
    logic                       sample;

    logic [7:0] rom_mem [0:(1 << `SND_ROM_AW) - 1];
    int ad_pending [$];     // decoded samples not yet paired with fm
    int expect_q [$];       // expected mixer outputs, in order
    int fm_todo = 0;        // pushes still requested from the fm source
    int fm_gap = 0;         // idle cycles between fm pushes
    bit loud_fm = 1'b0;     // near full scale fm
    int rom_extra = 0;      // slow rom
    int push_count = 0;
    int credit_count = 0;

    `include "snd_board_ref.svh"

    snd_board_top dut0 (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .addr      ( addr      ),
        .wdata     ( wdata     ),
        .wr        ( wr        ),
        .rdata     ( rdata     ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .fm_push   ( fm_push   ),
        .fm_data   ( fm_data   ),
        .fm_credit ( fm_credit ),
        .sound     ( sound     ),
        .sample    ( sample    )
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic check_value(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reg_write(input logic [2:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(posedge clk); // taken here
        #1;
        wr = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] a, output logic [7:0] d);
        @(posedge clk);
        #1;
        addr = a;
        @(negedge clk);
        d = rdata; // combinational, settled by mid cycle
    endtask

    task automatic write_readback(input logic [2:0] a, input logic [7:0] d);
        logic [7:0] v;
        reg_write(a, d);
        reg_read(a, v);
        check_value(v, d, "register readback");
    endtask

    // wait until every fm push has left the mixer
    task automatic drain();
        while (fm_todo != 0 || expect_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic play_voice(input int start, input int len, input int extra, input bit replay);
        logic [7:0] v;
        drain(); // fm paused and empty before play
        reg_write(snd_bus_pkg::REG_START_LO, start[7:0]);
        reg_write(snd_bus_pkg::REG_START_MID, start[15:8]);
        reg_write(snd_bus_pkg::REG_START_HI, {6'd0, start[17:16]});
        reg_write(snd_bus_pkg::REG_LENGTH, 8'(len));
        decode_range(start, len + 1);
        reg_write(snd_bus_pkg::REG_CTRL, 8'h01);
        reg_read(snd_bus_pkg::REG_STATUS, v);
        check_value(v[snd_bus_pkg::STAT_BUSY], 1, "busy right after play");
        fm_todo = 2 * (len + 1); // one fm partner per nibble
        if (replay) begin
            reg_write(snd_bus_pkg::REG_START_LO, start[7:0] + 8'h40);
            reg_write(snd_bus_pkg::REG_CTRL, 8'h01); // voice still busy
        end
        while (fm_todo != 0)
            @(posedge clk);
        v = 8'h01;
        while (v[snd_bus_pkg::STAT_BUSY])
            reg_read(snd_bus_pkg::REG_STATUS, v);
        fm_todo = extra; // silent voice, pass-through again
        drain();
    endtask

    // external fm source, own credit count
    initial begin : fm_source
        int credits;
        int wait_cnt;
        int ad;
        int fm;
        fm_push  = 1'b0;
        fm_data  = '0;
        credits  = `SND_FIFO_DEPTH;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            fm_push = 1'b0;
            if (fm_credit)
                credits++; // slot handed back
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else if (!reset && fm_todo > 0 && credits > 0) begin
                if (ad_pending.size() > 0)
                    ad = ad_pending.pop_front();
                else
                    ad = 0; // idle voice mixes as zero
                if (loud_fm)
                    fm = (ad >= 0) ? 32767 - int'($urandom_range(255))
                                   : -32768 + int'($urandom_range(255));
                else
                    fm = int'($urandom_range(16000)) - 8000;
                fm_data = 16'(fm);
                fm_push = 1'b1;
                credits--;
                fm_todo--;
                push_count++;
                expect_q.push_back(mix_expect(fm, ad));
                wait_cnt = fm_gap;
            end
        end
    end

    // sample rom, answers after 0..3 cycles plus rom_extra
    initial begin : rom_model
        int delay;
        logic [`SND_ROM_AW-1:0] req_addr;
        rom_ok   = 1'b0;
        rom_data = '0;
        delay    = -1;
        req_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ok) begin
                check_value(rom_cs, 0, "rom_cs drop after rom_ok");
                rom_ok = 1'b0; // byte taken
            end else if (rom_cs) begin
                if (delay < 0) begin
                    delay    = int'($urandom_range(3)) + rom_extra; // new request
                    req_addr = rom_addr;
                end
                check_value(rom_addr, req_addr, "rom address held during request");
                if (delay == 0) begin
                    rom_data = rom_mem[rom_addr];
                    rom_ok   = 1'b1;
                end
                delay--;
            end
        end
    end

    initial begin : compare
        int exp;
        forever begin
            @(negedge clk);
            if (fm_credit)
                credit_count++;
            if (sample) begin
                if (expect_q.size() == 0) begin
                    $display("output sample appeared with no fm push behind it");
                    $display("Verification failed");
                    $fatal(1, "extra sample");
                end else begin
                    exp = expect_q.pop_front();
                    check_value(sound, exp, "mixed output");
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog timeout: output samples missing");
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin : main
        int seed;
        logic [7:0] v;
        seed  = $urandom(32'hc363); // single seed for the run
        reset = 1'b1;
        addr  = '0;
        wdata = '0;
        wr    = 1'b0;
        for (int a = 0; a < (1 << `SND_ROM_AW); a++)
            rom_mem[a] = 8'($urandom);
        for (int a = 0; a < 6; a++)
            rom_mem[LOUD_BASE + a] = (a < 3) ? 8'h77 : 8'hff; // climb, then fall
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // register readback
        reg_read(snd_bus_pkg::REG_STATUS, v);
        check_value(v, 0, "status after reset");
        write_readback(snd_bus_pkg::REG_START_LO, 8'h5a);
        write_readback(snd_bus_pkg::REG_START_MID, 8'hc3);
        write_readback(snd_bus_pkg::REG_START_HI, 8'h02);
        write_readback(snd_bus_pkg::REG_LENGTH, 8'h9e);
        reg_read(3'd7, v);
        check_value(v, 0, "unused address");

        fm_gap  = 2;
        fm_todo = 20; // pass-through, voice idle
        drain();

        fm_gap = 3;
        play_voice(32'h01234, 6, 10, 1'b0);

        loud_fm = 1'b1; // saturation both ways
        play_voice(LOUD_BASE, 5, 4, 1'b0);
        loud_fm = 1'b0;

        fm_gap    = 0; // burst until credits run out
        rom_extra = 6;
        play_voice(32'h2a000, 3, 24, 1'b0);
        rom_extra = 0;

        fm_gap = 2;
        play_voice(32'h00800, 4, 4, 1'b1); // second play while busy

        repeat (4) @(posedge clk); // last credit pulse
        check_value(credit_count, push_count, "fm credit pulses");
        $display("Verification passed");
        $finish;
    end

endmodule

//--- source/snd_board_top.sv
`include "snd_params.svh"

module snd_board_top (
    input  logic                        clk,
    input  logic                        reset,
    // host bus
    input  logic [2:0]                  addr,
    input  logic [7:0]                  wdata,
    input  logic                        wr,
    output logic [7:0]                  rdata,
    // sample rom
    output logic [`SND_ROM_AW-1:0]      rom_addr,
    output logic                        rom_cs,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    // external fm source
    input  logic                        fm_push,
    input  snd_audio_pkg::fm_sample_t   fm_data,
    output logic                        fm_credit,
    // sound output
    output snd_audio_pkg::mix_sample_t  sound,
    output logic                        sample
);

    logic                         play;
    logic [`SND_ROM_AW-1:0]       start_addr;
    logic [7:0]                   length;
    logic                         busy;

    logic                         ad_push;
    snd_audio_pkg::adpcm_sample_t ad_din;
    logic                         ad_credit;
    logic                         ad_empty;
    logic                         ad_pop;
    snd_audio_pkg::adpcm_sample_t ad_dout;

    logic                         fm_empty;
    logic                         fm_pop;
    snd_audio_pkg::fm_sample_t    fm_dout;

    snd_regs u_regs (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .addr       ( addr       ),
        .wdata      ( wdata      ),
        .wr         ( wr         ),
        .rdata      ( rdata      ),
        .busy       ( busy       ),
        .play       ( play       ),
        .start_addr ( start_addr ),
        .length     ( length     )
    );

    adpcm_voice u_voice (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .play       ( play       ),
        .start_addr ( start_addr ),
        .length     ( length     ),
        .busy       ( busy       ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .push       ( ad_push    ),
        .data       ( ad_din     ),
        .credit     ( ad_credit  )
    );

    sample_fifo #(.payload_t(snd_audio_pkg::adpcm_sample_t)) u_ad_fifo (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .push   ( ad_push   ),
        .din    ( ad_din    ),
        .credit ( ad_credit ),
        .pop    ( ad_pop    ),
        .empty  ( ad_empty  ),
        .dout   ( ad_dout   )
    );

    // fm credits go straight back out, the source keeps the count
    sample_fifo #(.payload_t(snd_audio_pkg::fm_sample_t)) u_fm_fifo (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .push   ( fm_push   ),
        .din    ( fm_data   ),
        .credit ( fm_credit ),
        .pop    ( fm_pop    ),
        .empty  ( fm_empty  ),
        .dout   ( fm_dout   )
    );

    snd_mixer u_mixer (
        .clk        ( clk      ),
        .reset      ( reset    ),
        .fm_empty   ( fm_empty ),
        .fm_data    ( fm_dout  ),
        .fm_pop     ( fm_pop   ),
        .ad_empty   ( ad_empty ),
        .ad_data    ( ad_dout  ),
        .ad_pop     ( ad_pop   ),
        .voice_busy ( busy     ),
        .sound      ( sound    ),
        .sample     ( sample   )
    );

endmodule

//--- source/snd_mixer.sv
module snd_mixer (
    input  logic                          clk,
    input  logic                          reset,
    // fm fifo
    input  logic                          fm_empty,
    input  snd_audio_pkg::fm_sample_t     fm_data,
    output logic                          fm_pop,
    // adpcm fifo
    input  logic                          ad_empty,
    input  snd_audio_pkg::adpcm_sample_t  ad_data,
    output logic                          ad_pop,
    input  logic                          voice_busy,
    // output
    output snd_audio_pkg::mix_sample_t    sound,
    output logic                          sample
);

    logic                         go;
    snd_audio_pkg::adpcm_sample_t ad_val;
    logic signed [17:0]           fm_ext;
    logic signed [17:0]           ad_ext;
    logic signed [17:0]           ext;
    logic signed [17:0]           total;
    snd_audio_pkg::mix_sample_t   sat;

    // fm paces the output, adpcm joins when it has data
    // a busy voice with nothing queued holds everything back
    assign go     = !fm_empty && (!ad_empty || !voice_busy);
    assign fm_pop = go;
    assign ad_pop = go && !ad_empty;

    always_comb begin
        ad_val = ad_empty ? '0 : ad_data; // silent voice
        fm_ext = fm_data;
        ad_ext = ad_val;
        ext    = ad_ext <<< 2;               // 12 to 14 bit range
        total  = fm_ext + ext + (ext >>> 1); // 1.5x gain on adpcm
        if (total > 18'sd32767)
            sat = 16'sh7fff;
        else if (total < -18'sd32768)
            sat = 16'sh8000;
        else
            sat = total[15:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sound  <= '0;
            sample <= 1'b0;
        end else begin
            sample <= go; // strobe for the new value
            if (go)
                sound <= sat;
        end
    end

endmodule

//--- source/sample_fifo.sv
`include "snd_params.svh"

module sample_fifo #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     reset,
    // producer side
    input  logic     push,
    input  payload_t din,
    output logic     credit,  // one pulse per pop, a cycle later
    // consumer side
    input  logic     pop,
    output logic     empty,
    output payload_t dout
);

    localparam int AW = `SND_FIFO_AW;

    payload_t       mem [`SND_FIFO_DEPTH];
    logic [AW:0]    wr_ptr; // msb is the wrap bit
    logic [AW:0]    rd_ptr;

    // no full flag, producer credits keep it from overflowing
    assign empty = (wr_ptr == rd_ptr);
    assign dout  = mem[rd_ptr[AW-1:0]]; // head entry

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
            credit <= pop && !empty; // hands the slot back
        end
    end

    // storage, written at the push edge
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= din;
    end

endmodule

//--- source/adpcm_voice.sv
`include "snd_params.svh"

module adpcm_voice (
    input  logic                        clk,
    input  logic                        reset,
    // playback descriptor
    input  logic                        play,
    input  logic [`SND_ROM_AW-1:0]      start_addr,
    input  logic [7:0]                  length,
    output logic                        busy,
    // sample rom
    output logic [`SND_ROM_AW-1:0]      rom_addr,
    output logic                        rom_cs,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    // credit link to the adpcm fifo
    output logic                        push,
    output snd_audio_pkg::adpcm_sample_t data,
    input  logic                        credit
);

    localparam int DIV_W = $clog2(`SND_ADPCM_DIV);
    localparam logic [DIV_W-1:0] DIV_TOP = DIV_W'(`SND_ADPCM_DIV - 1);
    localparam int CW = `SND_FIFO_AW + 1; // holds 0..depth

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH, // rom_cs up, waiting for rom_ok
        ST_HI,    // high nibble pending
        ST_LO     // low nibble pending
    } state_t;

    state_t                       state;
    logic [7:0]                   remain;   // bytes left after the current one
    logic [7:0]                   byte_q;
    logic [DIV_W-1:0]             div_cnt;
    logic [CW-1:0]                credits;
    snd_audio_pkg::adpcm_sample_t sample_q; // decoder accumulator
    logic [5:0]                   index_q;  // step table index

    logic [3:0]                   nib;
    logic [10:0]                  step;
    logic [11:0]                  diff;     // up to 2910
    logic signed [13:0]           sample_ext;
    logic signed [13:0]           sum;
    logic signed [6:0]            idx_sum;
    snd_audio_pkg::adpcm_sample_t new_sample;
    logic [5:0]                   new_index;

    assign busy = (state != ST_IDLE);

    // msm6295 nibble decode
    always_comb begin
        nib  = (state == ST_HI) ? byte_q[7:4] : byte_q[3:0];
        step = snd_audio_pkg::STEP_TABLE[index_q];
        diff = 12'(step >> 3);
        if (nib[0]) diff = diff + 12'(step >> 2);
        if (nib[1]) diff = diff + 12'(step >> 1);
        if (nib[2]) diff = diff + 12'(step);
        sample_ext = sample_q; // sign extends
        if (nib[3])
            sum = sample_ext - $signed({2'b00, diff});
        else
            sum = sample_ext + $signed({2'b00, diff});
        // clamp to +-2047
        if (sum > 14'(snd_audio_pkg::ADPCM_LIMIT))
            new_sample = 12'(snd_audio_pkg::ADPCM_LIMIT);
        else if (sum < -14'(snd_audio_pkg::ADPCM_LIMIT))
            new_sample = -12'(snd_audio_pkg::ADPCM_LIMIT);
        else
            new_sample = sum[11:0];
        idx_sum = $signed({1'b0, index_q}) + 7'(snd_audio_pkg::INDEX_ADJ[nib[2:0]]);
        if (idx_sum < 0)
            new_index = 6'd0;
        else if (idx_sum > 7'(snd_audio_pkg::STEP_MAX))
            new_index = 6'(snd_audio_pkg::STEP_MAX);
        else
            new_index = idx_sum[5:0];
    end

    // nibble goes out when paced, and only with credit left
    assign push = (state == ST_HI || state == ST_LO) && (div_cnt == DIV_TOP)
                  && (credits != '0);
    assign data = new_sample;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            remain   <= '0;
            div_cnt  <= '0;
            sample_q <= '0;
            index_q  <= '0;
            credits  <= CW'(`SND_FIFO_DEPTH);
        end else begin
            case ({push, credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ; // none, or spent and returned together
            endcase
            if (busy && div_cnt != DIV_TOP)
                div_cnt <= div_cnt + 1'b1; // saturates at the top
            case (state)
                ST_IDLE: if (play) begin // replay while busy never gets here
                    rom_addr <= start_addr;
                    remain   <= length;
                    sample_q <= '0;
                    index_q  <= '0;
                    div_cnt  <= '0;
                    rom_cs   <= 1'b1;
                    state    <= ST_FETCH;
                end
                ST_FETCH: if (rom_ok) begin
                    rom_cs <= 1'b0; // low for at least a cycle
                    state  <= ST_HI;
                end
                ST_HI: if (push) begin
                    sample_q <= new_sample;
                    index_q  <= new_index;
                    div_cnt  <= '0;
                    state    <= ST_LO;
                end
                ST_LO: if (push) begin
                    sample_q <= new_sample;
                    index_q  <= new_index;
                    div_cnt  <= '0;
                    if (remain == 8'd0) begin
                        state <= ST_IDLE; // busy drops with the last push
                    end else begin
                        rom_addr <= rom_addr + 1'b1;
                        remain   <= remain - 1'b1;
                        rom_cs   <= 1'b1;
                        state    <= ST_FETCH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // rom byte capture
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && rom_ok)
            byte_q <= rom_data;
    end

endmodule

//--- source/snd_regs.sv
`include "snd_params.svh"

module snd_regs (
    input  logic                    clk,
    input  logic                    reset,
    // host bus
    input  logic [2:0]              addr,
    input  logic [7:0]              wdata,
    input  logic                    wr,
    output logic [7:0]              rdata,
    // voice side
    input  logic                    busy,
    output logic                    play,
    output logic [`SND_ROM_AW-1:0]  start_addr,
    output logic [7:0]              length
);

    logic [7:0] start_lo;
    logic [7:0] start_mid;
    logic [1:0] start_hi;  // only 2 bits used of the upper byte
    logic [7:0] length_q;
    logic [7:0] status;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_lo  <= '0;
            start_mid <= '0;
            start_hi  <= '0;
            length_q  <= '0;
            play      <= 1'b0;
        end else begin
            play <= 1'b0; // single cycle pulse
            if (wr) begin
                case (addr)
                    snd_bus_pkg::REG_START_LO:  start_lo  <= wdata;
                    snd_bus_pkg::REG_START_MID: start_mid <= wdata;
                    snd_bus_pkg::REG_START_HI:  start_hi  <= wdata[1:0];
                    snd_bus_pkg::REG_LENGTH:    length_q  <= wdata;
                    snd_bus_pkg::REG_CTRL:      play      <= wdata[snd_bus_pkg::CTRL_PLAY];
                    default: ; // status is read only
                endcase
            end
        end
    end

    assign start_addr = {start_hi, start_mid, start_lo};
    assign length     = length_q;

    always_comb begin
        status = '0;
        status[snd_bus_pkg::STAT_BUSY] = busy;
    end

    // read mux, unused addresses give 0
    always_comb begin
        case (addr)
            snd_bus_pkg::REG_START_LO:  rdata = start_lo;
            snd_bus_pkg::REG_START_MID: rdata = start_mid;
            snd_bus_pkg::REG_START_HI:  rdata = {6'd0, start_hi};
            snd_bus_pkg::REG_LENGTH:    rdata = length_q;
            snd_bus_pkg::REG_STATUS:    rdata = status;
            default:                    rdata = 8'd0;
        endcase
    end

endmodule

//--- source/snd_audio_pkg.sv
package snd_audio_pkg;

    // decoded adpcm sample, range clamped to +-2047
    typedef logic signed [11:0] adpcm_sample_t;

    // fm synthesizer sample as delivered from outside
    typedef logic signed [15:0] fm_sample_t;

    // mixed board output
    typedef logic signed [15:0] mix_sample_t;

    // msm6295 step sizes, index 0..48
    localparam logic [10:0] STEP_TABLE [0:48] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,
        11'd25,   11'd28,   11'd31,   11'd34,   11'd37,
        11'd41,   11'd45,   11'd50,   11'd55,   11'd60,
        11'd66,   11'd73,   11'd80,   11'd88,   11'd97,
        11'd107,  11'd118,  11'd130,  11'd143,  11'd157,
        11'd173,  11'd190,  11'd209,  11'd230,  11'd253,
        11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,
        11'd724,  11'd796,  11'd876,  11'd963,  11'd1060,
        11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // step index change, picked by the low 3 nibble bits
    // small nibbles walk the step down, large ones jump up
    localparam logic signed [4:0] INDEX_ADJ [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1,
        5'sd2,  5'sd4,  5'sd6,  5'sd8
    };

    // last valid step index
    localparam int STEP_MAX = 48;

    // decoder output limit
    localparam int ADPCM_LIMIT = 2047;

endpackage

//--- source/snd_bus_pkg.sv
package snd_bus_pkg;

    // host register map, one byte each
    typedef enum logic [2:0] {
        REG_START_LO  = 3'd0, // start address bits 7:0
        REG_START_MID = 3'd1, // start address bits 15:8
        REG_START_HI  = 3'd2, // start address bits 17:16
        REG_LENGTH    = 3'd3, // byte count minus one
        REG_CTRL      = 3'd4, // write only, bit 0 starts playback
        REG_STATUS    = 3'd5  // read only
    } reg_addr_e;

    // control register bits
    localparam int CTRL_PLAY = 0;

    // status register bits
    localparam int STAT_BUSY = 0; // voice still fetching / decoding

endpackage

//--- source/snd_params.svh
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// sample rom address bus, 256 kB of adpcm data
`define SND_ROM_AW 18

// entries per sample fifo, also the initial credit count of a producer
`define SND_FIFO_DEPTH 8

// fifo pointer width, log2 of the depth
`define SND_FIFO_AW 3

// clk cycles between two decoded adpcm nibbles
`define SND_ADPCM_DIV 16

`endif
